// ==== design/digitizer_config.sv ====
module digitizer_config
	import digitizer_pkg::*;
#(
	parameter int n_chan = digitizer_pkg::n_chan,
	parameter int tap_w  = digitizer_pkg::tap_w
) (
	input  logic                     lb_clk,
	input  logic                     arst_n,
	input  logic                     lb_strobe,
	input  logic                     lb_rd,
	input  logic [23:0]              lb_addr,
	input  logic [31:0]              lb_dout,
	input  logic                     mmcm_locked,
	output logic [31:0]              lb_din,
	output logic                     pwr_en,
	output logic                     u2_pdwn,
	output logic                     u3_pdwn,
	output logic [7:0]               u2_bitslip,
	output logic [7:0]               u3_bitslip,
	output logic [1:0]               clk_status,
	output logic                     scan_running,
	output logic [n_chan-1:0]        idelay_ld,   // U2 in 7:0, U3 in 15:8
	output logic [n_chan*tap_w-1:0]  tap_values
);
	localparam int chan_w = $clog2(n_chan);

	logic              sweep_start;
	logic [tap_w-1:0]  sweep_base;
	logic              host_tap_stb;
	logic [chan_w-1:0] host_tap_chan;
	logic [tap_w-1:0]  host_tap_val;
	logic              sweep_stb;
	logic [chan_w-1:0] sweep_chan;
	logic [tap_w-1:0]  sweep_val;
	logic              ld_stb;   // merged load bus
	logic [chan_w-1:0] ld_chan;
	logic [tap_w-1:0]  ld_val;

	digitizer_regs #(.n_chan(n_chan), .tap_w(tap_w)) u_regs (
		.lb_clk(lb_clk), .arst_n(arst_n), .lb_strobe(lb_strobe), .lb_rd(lb_rd),
		.lb_addr(lb_addr), .lb_dout(lb_dout), .mmcm_locked(mmcm_locked),
		.scan_running(scan_running), .tap_values(tap_values), .lb_din(lb_din),
		.pwr_en(pwr_en), .u2_pdwn(u2_pdwn), .u3_pdwn(u3_pdwn),
		.u2_bitslip(u2_bitslip), .u3_bitslip(u3_bitslip), .clk_status(clk_status),
		.sweep_start(sweep_start), .sweep_base(sweep_base),
		.host_tap_stb(host_tap_stb), .host_tap_chan(host_tap_chan),
		.host_tap_val(host_tap_val)
	);

	idelay_autoset #(.n_chan(n_chan), .tap_w(tap_w)) u_autoset (
		.lb_clk(lb_clk), .arst_n(arst_n), .sweep_start(sweep_start),
		.sweep_base(sweep_base), .sweep_stb(sweep_stb), .sweep_chan(sweep_chan),
		.sweep_val(sweep_val), .scan_running(scan_running)
	);

	// host wins ties, sweeper write parks for a cycle
	idelay_arbiter #(.n_chan(n_chan), .tap_w(tap_w)) u_arbiter (
		.lb_clk(lb_clk), .arst_n(arst_n), .host_tap_stb(host_tap_stb),
		.host_tap_chan(host_tap_chan), .host_tap_val(host_tap_val),
		.sweep_stb(sweep_stb), .sweep_chan(sweep_chan), .sweep_val(sweep_val),
		.ld_stb(ld_stb), .ld_chan(ld_chan), .ld_val(ld_val)
	);

	idelay_loader #(.n_chan(n_chan), .tap_w(tap_w)) u_loader (
		.lb_clk(lb_clk), .arst_n(arst_n), .ld_stb(ld_stb), .ld_chan(ld_chan),
		.ld_val(ld_val), .idelay_ld(idelay_ld), .tap_values(tap_values)
	);

endmodule

// ==== design/digitizer_pkg.sv ====
package digitizer_pkg;

	// local bus register map, lb_clk domain
	localparam logic [23:0] addr_periph     = 24'd0; // bit 0 pwr_en, bit 1 adc pdwn
	localparam logic [23:0] addr_bitslip    = 24'd1; // U2 low byte, U3 high byte
	localparam logic [23:0] addr_clk_status = 24'd2; // wr bit 0 set up, bit 1 verified
	localparam logic [23:0] addr_autoset    = 24'd3; // base in 4:0, bit 8 starts a sweep
	localparam logic [23:0] addr_status     = 24'd4; // read only

	// tap window, low nibble is the channel
	localparam logic [19:0] idelay_page = 20'd7;

	// IDELAY geometry
	localparam int tap_w  = 5;
	localparam int n_chan = 16; // 0-7 on U2, 8-15 on U3

	// mmcm tracker states
	localparam logic [1:0] cs_reset    = 2'd0; // out of reset or lost lock
	localparam logic [1:0] cs_frozen   = 2'd1; // clocks set up
	localparam logic [1:0] cs_verified = 2'd2; // checked with PRNG data

	// sweeper pacing, cycles from one tap write to the next
	// wide enough that the arbiter pending slot never overflows
	localparam int sweep_gap = 4;

endpackage

// ==== design/digitizer_regs.sv ====
module digitizer_regs
	import digitizer_pkg::*;
#(
	parameter int n_chan = digitizer_pkg::n_chan,
	parameter int tap_w  = digitizer_pkg::tap_w
) (
	input  logic                       lb_clk,
	input  logic                       arst_n,
	input  logic                       lb_strobe,
	input  logic                       lb_rd,
	input  logic [23:0]                lb_addr,
	input  logic [31:0]                lb_dout,       // write data from host
	input  logic                       mmcm_locked,
	input  logic                       scan_running,
	input  logic [n_chan*tap_w-1:0]    tap_values,    // current taps, for readback
	output logic [31:0]                lb_din,        // read data to host
	output logic                       pwr_en,
	output logic                       u2_pdwn,
	output logic                       u3_pdwn,
	output logic [7:0]                 u2_bitslip,
	output logic [7:0]                 u3_bitslip,
	output logic [1:0]                 clk_status,
	output logic                       sweep_start,
	output logic [tap_w-1:0]           sweep_base,
	output logic                       host_tap_stb,
	output logic [$clog2(n_chan)-1:0]  host_tap_chan,
	output logic [tap_w-1:0]           host_tap_val
);
	localparam int chan_w = $clog2(n_chan);

	logic        wr;
	logic        rd;
	logic        in_tap_page;
	logic [31:0] periph_config;
	logic [15:0] bitslip;
	logic [tap_w-1:0] tap_rd;
	logic [31:0] rd_data;

	assign wr = lb_strobe & ~lb_rd;
	assign rd = lb_strobe & lb_rd;
	assign in_tap_page = (lb_addr[23:4] == idelay_page);

	// tap writes go straight to the arbiter, same cycle as the strobe
	assign host_tap_stb  = wr & in_tap_page;
	assign host_tap_chan = lb_addr[chan_w-1:0];
	assign host_tap_val  = lb_dout[tap_w-1:0];

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			periph_config <= '0; // power off
			bitslip       <= '0;
			sweep_base    <= '0;
			sweep_start   <= 1'b0;
		end else begin
			// one-cycle pulse, sweeper ignores it while busy
			sweep_start <= wr && (lb_addr == addr_autoset) && lb_dout[8];
			if (wr && (lb_addr == addr_periph))
				periph_config <= lb_dout;
			if (wr && (lb_addr == addr_bitslip))
				bitslip <= lb_dout[15:0];
			if (wr && (lb_addr == addr_autoset))
				sweep_base <= lb_dout[tap_w-1:0];
		end
	end

	assign pwr_en     = periph_config[0];
	assign u2_pdwn    = periph_config[1]; // one pdwn bit drives both ADCs
	assign u3_pdwn    = periph_config[1];
	assign u2_bitslip = bitslip[7:0];
	assign u3_bitslip = bitslip[15:8];

	// mmcm tracker, sticky until lock drops
	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_status <= cs_reset;
		end else begin
			if (wr && (lb_addr == addr_clk_status)) begin
				if (lb_dout[0])
					clk_status <= cs_frozen;
				if (lb_dout[1] && (clk_status == cs_frozen))
					clk_status <= cs_verified; // verify only counts once frozen
			end
			if (!mmcm_locked)
				clk_status <= cs_reset; // lost lock beats any write
		end
	end

	// tap readback from the loader's copy
	assign tap_rd = tap_values[int'(lb_addr[chan_w-1:0])*tap_w +: tap_w];

	always_comb begin
		rd_data = '0;
		case (lb_addr)
			addr_periph:     rd_data = periph_config;
			addr_bitslip:    rd_data = {16'h0, bitslip};
			addr_clk_status: rd_data = {30'h0, clk_status};
			addr_autoset:    rd_data = 32'(sweep_base);
			addr_status:     rd_data = {29'h0, scan_running, clk_status};
			default: begin
				if (in_tap_page)
					rd_data = 32'(tap_rd);
			end
		endcase
	end

	// registered read port, holds between reads
	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n)
			lb_din <= '0;
		else if (rd)
			lb_din <= rd_data;
	end

endmodule

// ==== design/idelay_arbiter.sv ====
module idelay_arbiter
	import digitizer_pkg::*;
#(
	parameter int n_chan = digitizer_pkg::n_chan,
	parameter int tap_w  = digitizer_pkg::tap_w
) (
	input  logic                       lb_clk,
	input  logic                       arst_n,
	input  logic                       host_tap_stb,
	input  logic [$clog2(n_chan)-1:0]  host_tap_chan,
	input  logic [tap_w-1:0]           host_tap_val,
	input  logic                       sweep_stb,
	input  logic [$clog2(n_chan)-1:0]  sweep_chan,
	input  logic [tap_w-1:0]           sweep_val,
	output logic                       ld_stb,
	output logic [$clog2(n_chan)-1:0]  ld_chan,
	output logic [tap_w-1:0]           ld_val
);
	localparam int chan_w = $clog2(n_chan);

	logic              pend_vld;
	logic [chan_w-1:0] pend_chan;
	logic [tap_w-1:0]  pend_val;
	logic              park;

	// sweeper loses to host, or to an older parked write
	assign park = sweep_stb & (host_tap_stb | pend_vld);

	// host first, then parked sweeper write, then live sweeper write
	always_comb begin
		ld_stb  = host_tap_stb | pend_vld | sweep_stb;
		ld_chan = sweep_chan;
		ld_val  = sweep_val;
		if (host_tap_stb) begin
			ld_chan = host_tap_chan;
			ld_val  = host_tap_val;
		end else if (pend_vld) begin
			ld_chan = pend_chan;
			ld_val  = pend_val;
		end
	end

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n)
			pend_vld <= 1'b0;
		else if (park)
			pend_vld <= 1'b1;
		else if (!host_tap_stb)
			pend_vld <= 1'b0; // drained this cycle
	end

	always_ff @(posedge lb_clk) begin
		if (park) begin
			pend_chan <= sweep_chan;
			pend_val  <= sweep_val;
		end
	end

endmodule

// ==== design/idelay_autoset.sv ====
module idelay_autoset
	import digitizer_pkg::*;
#(
	parameter int n_chan = digitizer_pkg::n_chan,
	parameter int tap_w  = digitizer_pkg::tap_w
) (
	input  logic                       lb_clk,
	input  logic                       arst_n,
	input  logic                       sweep_start,  // one-cycle trigger
	input  logic [tap_w-1:0]           sweep_base,
	output logic                       sweep_stb,
	output logic [$clog2(n_chan)-1:0]  sweep_chan,
	output logic [tap_w-1:0]           sweep_val,
	output logic                       scan_running
);
	localparam int chan_w = $clog2(n_chan);
	localparam int gap_w  = $clog2(sweep_gap + 1);
	localparam logic [chan_w-1:0] last_chan = chan_w'(n_chan - 1);

	logic             busy;
	logic             start_ok;
	logic [gap_w-1:0] gap_cnt;   // cycles left before next write
	logic [tap_w-1:0] base_q;

	assign start_ok = sweep_start & ~busy; // retrigger while busy is dropped

	// up as soon as the trigger shows, down after the last write
	assign scan_running = busy | sweep_start;

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			busy       <= 1'b0;
			sweep_stb  <= 1'b0;
			sweep_chan <= '0;
			gap_cnt    <= '0;
		end else begin
			sweep_stb <= 1'b0;
			if (start_ok) begin
				busy       <= 1'b1;
				sweep_stb  <= 1'b1; // channel 0 right away
				sweep_chan <= '0;
				gap_cnt    <= gap_w'(sweep_gap - 1);
			end else if (busy) begin
				if (sweep_stb && (sweep_chan == last_chan)) begin
					busy <= 1'b0; // last channel just went out
				end else if (gap_cnt != '0) begin
					gap_cnt <= gap_cnt - 1'b1;
				end else begin
					sweep_stb  <= 1'b1;
					sweep_chan <= sweep_chan + 1'b1;
					gap_cnt    <= gap_w'(sweep_gap - 1);
				end
			end
		end
	end

	// base latched once per sweep
	always_ff @(posedge lb_clk) begin
		if (start_ok)
			base_q <= sweep_base;
	end

	// base plus channel index, wraps at tap range
	assign sweep_val = base_q + tap_w'(sweep_chan);

endmodule

// ==== design/idelay_loader.sv ====
module idelay_loader
	import digitizer_pkg::*;
#(
	parameter int n_chan = digitizer_pkg::n_chan,
	parameter int tap_w  = digitizer_pkg::tap_w
) (
	input  logic                       lb_clk,
	input  logic                       arst_n,
	input  logic                       ld_stb,
	input  logic [$clog2(n_chan)-1:0]  ld_chan,
	input  logic [tap_w-1:0]           ld_val,
	output logic [n_chan-1:0]          idelay_ld,   // LD pins of the delay lines
	output logic [n_chan*tap_w-1:0]    tap_values   // CNTVALUEIN, also readback
);
	localparam int chan_w = $clog2(n_chan);

	//  ld_stb         __--__________
	//  tap            xx--VVVVVVVVVV
	//  idelay_ld[c]   ______----____
	// two lb_clk cycles of LD, in case the IDELAY clock is slower
	for (genvar c = 0; c < n_chan; c++) begin : g_chan
		logic             hit;
		logic [1:0]       sr;    // strobe history for this channel
		logic             ld_q;
		logic [tap_w-1:0] tap_q;

		assign hit = ld_stb && (ld_chan == chan_w'(c));

		always_ff @(posedge lb_clk or negedge arst_n) begin
			if (!arst_n) begin
				sr    <= '0;
				ld_q  <= 1'b0;
				tap_q <= '0;
			end else begin
				sr   <= {sr[0], hit};
				ld_q <= |sr; // either stage keeps LD up
				if (hit)
					tap_q <= ld_val; // value settles before LD rises
			end
		end

		assign idelay_ld[c] = ld_q;
		assign tap_values[c*tap_w +: tap_w] = tap_q;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build and run the testbench, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module digitizer_config_tb -f tb.f -o digitizer_config_tb > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/digitizer_config_tb > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== sim/digitizer_checker.sv ====
module digitizer_checker
	import digitizer_pkg::*;
#(
	parameter int n_chan = digitizer_pkg::n_chan,
	parameter int tap_w  = digitizer_pkg::tap_w
) (
	input  logic                      lb_clk,
	input  logic                      arst_n,
	input  logic                      lb_strobe,
	input  logic                      lb_rd,
	input  logic [23:0]               lb_addr,
	input  logic [31:0]               lb_dout,
	input  logic                      mmcm_locked,
	input  logic [31:0]               lb_din,
	input  logic                      pwr_en,
	input  logic                      u2_pdwn,
	input  logic                      u3_pdwn,
	input  logic [7:0]                u2_bitslip,
	input  logic [7:0]                u3_bitslip,
	input  logic [1:0]                clk_status,
	input  logic                      scan_running,
	input  logic [n_chan-1:0]         idelay_ld,
	input  logic [n_chan*tap_w-1:0]   tap_values,
	output int                        errors
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int chan_w = $clog2(n_chan);
	localparam int sweep_len = 2 + sweep_gap * (n_chan - 1); // trigger edge to busy drop

	// model state stepped once per lb_clk edge
	int               cyc;
	logic [31:0]      m_periph;
	logic [15:0]      m_bits;
	logic [tap_w-1:0] m_base;
	logic [1:0]       m_cs;
	logic [tap_w-1:0] m_tap [n_chan];
	logic             sw_active;
	int               sw_k;       // edge of the autoset write
	logic [tap_w-1:0] sw_base;
	logic             pend_v;     // arbiter pending slot
	int               pend_c;
	logic [tap_w-1:0] pend_val;
	logic [n_chan-1:0] h1, h2, h3; // loads one, two, three edges back
	logic [n_chan-1:0] load_v;
	logic [31:0]      rd_exp;
	logic             running;
	logic             wr;
	logic             host;
	logic             sw_due;
	int               sw_c;

	// clock-status state rule
	function automatic logic [1:0] clk_next(logic [1:0] cur, logic cs_wr, logic [31:0] d,
			logic locked);
		logic [1:0] nxt;
		nxt = cur;
		if (cs_wr && d[1] && cur == cs_frozen)
			nxt = cs_verified;
		else if (cs_wr && d[0])
			nxt = cs_frozen;
		if (!locked)
			nxt = cs_reset; // lock loss wins
		return nxt;
	endfunction

	function automatic logic [tap_w-1:0] sweep_tap(logic [tap_w-1:0] base, int c);
		return tap_w'(base + c); // wraps at 32
	endfunction

	function automatic logic [31:0] read_exp(logic [23:0] a);
		logic [31:0] r;
		r = '0;
		case (a)
			addr_periph:     r = m_periph;
			addr_bitslip:    r = {16'h0, m_bits};
			addr_clk_status: r = {30'h0, m_cs};
			addr_autoset:    r = 32'(m_base);
			addr_status:     r = {29'h0, running, m_cs};
			default: begin
				if (a[23:4] == idelay_page)
					r = 32'(m_tap[a[chan_w-1:0]]);
			end
		endcase
		return r;
	endfunction

	task automatic check_val(string name, logic [31:0] exp, logic [31:0] got);
		if (exp !== got) begin
			errors++;
			$display("error %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic load_tap(int c, logic [tap_w-1:0] v);
		m_tap[c] = v;
		load_v[c] = 1'b1;
	endtask

	initial errors = 0;

	always @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc = 0;
			m_periph = '0;
			m_bits = '0;
			m_base = '0;
			m_cs = cs_reset;
			for (int c = 0; c < n_chan; c++)
				m_tap[c] = '0;
			sw_active = 1'b0;
			sw_k = 0;
			sw_base = '0;
			pend_v = 1'b0;
			{h1, h2, h3} = '0;
			rd_exp = '0;
		end else begin
			cyc++;
			running = sw_active && cyc >= sw_k + 1 && cyc <= sw_k + sweep_len;
			// compare what the DUT shows for the last cycle
			check_val("lb_din", rd_exp, lb_din); // holds between reads
			check_val("pwr_en", 32'(m_periph[0]), 32'(pwr_en));
			check_val("u2_pdwn", 32'(m_periph[1]), 32'(u2_pdwn));
			check_val("u3_pdwn", 32'(m_periph[1]), 32'(u3_pdwn));
			check_val("u2_bitslip", 32'(m_bits[7:0]), 32'(u2_bitslip));
			check_val("u3_bitslip", 32'(m_bits[15:8]), 32'(u3_bitslip));
			check_val("clk_status", 32'(m_cs), 32'(clk_status));
			check_val("scan_running", 32'(running), 32'(scan_running));
			check_val("idelay_ld", 32'(h2 | h3), 32'(idelay_ld)); // two cycles long and two late
			for (int c = 0; c < n_chan; c++)
				check_val($sformatf("tap_values[%0d]", c), 32'(m_tap[c]),
					32'(tap_values[c*tap_w +: tap_w]));

			if (lb_strobe && lb_rd)
				rd_exp = read_exp(lb_addr);

			// arbiter rule with host first and the parked sweep write next
			wr = lb_strobe && !lb_rd;
			host = wr && (lb_addr[23:4] == idelay_page);
			sw_due = sw_active && cyc >= sw_k + 2 && (cyc - sw_k - 2) % sweep_gap == 0
				&& (cyc - sw_k - 2) / sweep_gap < n_chan;
			sw_c = (cyc - sw_k - 2) / sweep_gap;
			load_v = '0;
			if (host) begin
				load_tap(int'(lb_addr[chan_w-1:0]), lb_dout[tap_w-1:0]);
				if (sw_due) begin
					pend_v = 1'b1;
					pend_c = sw_c;
					pend_val = sweep_tap(sw_base, sw_c);
				end
			end else if (pend_v) begin
				load_tap(pend_c, pend_val);
				pend_v = sw_due;
				if (sw_due) begin
					pend_c = sw_c;
					pend_val = sweep_tap(sw_base, sw_c);
				end
			end else if (sw_due) begin
				load_tap(sw_c, sweep_tap(sw_base, sw_c));
			end
			h3 = h2;
			h2 = h1;
			h1 = load_v;

			// register writes
			if (wr && lb_addr == addr_periph)
				m_periph = lb_dout;
			if (wr && lb_addr == addr_bitslip)
				m_bits = lb_dout[15:0];
			if (wr && lb_addr == addr_autoset) begin
				m_base = lb_dout[tap_w-1:0];
				if (lb_dout[8] && !(sw_active && cyc < sw_k + sweep_len)) begin
					sw_active = 1'b1;
					sw_k = cyc;
					sw_base = lb_dout[tap_w-1:0];
				end
			end
			m_cs = clk_next(m_cs, wr && lb_addr == addr_clk_status, lb_dout, mmcm_locked);
		end
	end

endmodule

// ==== sim/digitizer_config_sva.sv ====
module digitizer_config_sva #(
	parameter int n_chan = 16
) (
	input logic                      lb_clk,
	input logic                      arst_n,
	input logic                      ld_stb,
	input logic [$clog2(n_chan)-1:0] ld_chan,
	input logic [n_chan-1:0]         idelay_ld
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [n_chan-1:0] hit_v; // one-hot load this cycle

	assign hit_v = ld_stb ? (n_chan'(1) << ld_chan) : '0;

	for (genvar c = 0; c < n_chan; c++) begin : g_ld
		// a load gives LD for the two cycles after edges t+1 and t+2
		a_ld_two: assert property (@(posedge lb_clk) disable iff (!arst_n)
			hit_v[c] |-> ##2 idelay_ld[c] ##1 idelay_ld[c])
			else $error("load bit %0d not high for two cycles", c);
		// and never without such a load
		a_ld_cause: assert property (@(posedge lb_clk) disable iff (!arst_n)
			idelay_ld[c] |-> ($past(hit_v[c], 2) || $past(hit_v[c], 3)))
			else $error("load bit %0d high with no load behind it", c);
	end

	a_rst_idle: assert property (@(posedge lb_clk) $rose(arst_n) |-> (idelay_ld == '0 && !ld_stb))
		else $error("load outputs busy right after reset");

	a_rst_stb: assert property (@(posedge lb_clk) !arst_n |-> !ld_stb)
		else $error("ld_stb high during reset");

endmodule

bind idelay_loader digitizer_config_sva #(.n_chan(n_chan)) u_sva (
	.lb_clk(lb_clk), .arst_n(arst_n), .ld_stb(ld_stb), .ld_chan(ld_chan),
	.idelay_ld(idelay_ld)
);

// ==== sim/digitizer_config_tb.sv ====
module digitizer_config_tb
	import digitizer_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// cycle budget per test plus 20 percent for the watchdog
	localparam int test_cycles = 80 + 60 + 200 + 160 + 200;

	logic                     lb_clk, arst_n;
	logic                     lb_strobe, lb_rd, mmcm_locked;
	logic [23:0]              lb_addr;
	logic [31:0]              lb_dout, lb_din;
	logic                     pwr_en, u2_pdwn, u3_pdwn, scan_running;
	logic [7:0]               u2_bitslip, u3_bitslip;
	logic [1:0]               clk_status;
	logic [n_chan-1:0]        idelay_ld;
	logic [n_chan*tap_w-1:0]  tap_values;
	int                       chk_errors;
	int                       tb_errors;
	int                       n_pass, n_fail, err_mark;
	int                       polls;
	logic [tap_w-1:0]         base;

	tb_clkgen u_clk (.lb_clk(lb_clk), .arst_n(arst_n));

	digitizer_config #(.n_chan(n_chan), .tap_w(tap_w)) DUT (.*);

	digitizer_checker #(.n_chan(n_chan), .tap_w(tap_w)) u_chk (.*, .errors(chk_errors));

	task automatic bus_write(logic [23:0] a, logic [31:0] d);
		@(negedge lb_clk);
		lb_strobe = 1'b1;
		lb_rd = 1'b0;
		lb_addr = a;
		lb_dout = d;
		@(negedge lb_clk);
		lb_strobe = 1'b0; // at most one write every two cycles
	endtask

	task automatic bus_read(logic [23:0] a);
		@(negedge lb_clk);
		lb_strobe = 1'b1;
		lb_rd = 1'b1;
		lb_addr = a;
		@(negedge lb_clk);
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
	endtask

	task automatic idle(int n);
		repeat (n) @(negedge lb_clk);
	endtask

	task automatic wait_sweep();
		polls = 0;
		while (scan_running && polls < 100) begin
			bus_read(addr_status); // status bit 2 checked against model
			polls++;
		end
		if (scan_running) begin
			tb_errors++;
			$display("sweep still running after %0d status polls", polls);
		end
	endtask

	task automatic end_test(string name);
		repeat (2) @(negedge lb_clk); // last read data gets compared first
		if (chk_errors + tb_errors == err_mark)
			n_pass++;
		else
			n_fail++;
		$display("test %s done, %0d new errors", name, chk_errors + tb_errors - err_mark);
		err_mark = chk_errors + tb_errors;
	endtask

	initial begin
		#(test_cycles * 12 / 10 * 40);
		$display("timeout, the tests ran longer than their cycle budget");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		lb_addr = '0;
		lb_dout = '0;
		mmcm_locked = 1'b1;
		tb_errors = 0;
		n_pass = 0;
		n_fail = 0;
		err_mark = 0;
		void'($urandom(32'hea2d2970));
		@(posedge arst_n);

		// reset values then config registers
		for (int a = 0; a <= 4; a++)
			bus_read(24'(a));
		bus_read({idelay_page, 4'h0});
		bus_read(24'h10); // unmapped
		for (int i = 0; i < 4; i++) begin
			bus_write(addr_periph, $urandom);
			bus_read(addr_periph);
			bus_write(addr_bitslip, $urandom);
			bus_read(addr_bitslip);
		end
		end_test("reset_and_config");

		// mmcm tracker
		bus_write(addr_clk_status, 32'h2); // verify from reset stays 0
		bus_read(addr_clk_status);
		bus_write(addr_clk_status, 32'h1);
		bus_read(addr_clk_status);
		bus_write(addr_clk_status, 32'h2);
		bus_read(addr_clk_status);
		@(negedge lb_clk) mmcm_locked = 1'b0;
		@(negedge lb_clk) mmcm_locked = 1'b1;
		bus_read(addr_clk_status);
		bus_read(addr_status);
		end_test("clk_status");

		for (int i = 0; i < 20; i++) begin
			bus_write({idelay_page, 4'($urandom)}, 32'($urandom % 32));
			idle(4); // let the load pulse finish
			bus_read(lb_addr);
		end
		end_test("host_taps");

		base = tap_w'($urandom);
		bus_write(addr_autoset, {23'h0, 1'b1, 3'h0, base});
		wait_sweep();
		idle(4);
		for (int c = 0; c < n_chan; c++)
			bus_read({idelay_page, 4'(c)});
		bus_read(addr_status);
		bus_read(addr_autoset);
		end_test("sweep");

		// host writes land on sweeper strobes and some hit the same channel
		base = tap_w'($urandom);
		bus_write(addr_autoset, {23'h0, 1'b1, 3'h0, base});
		for (int i = 0; i < 20; i++)
			bus_write({idelay_page, 4'($urandom)}, 32'($urandom % 32));
		wait_sweep();
		idle(4);
		for (int c = 0; c < n_chan; c++)
			bus_read({idelay_page, 4'(c)});
		end_test("sweep_with_host");

		idle(2);
		$display("tests passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0 && chk_errors + tb_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim/tb_clkgen.sv ====
module tb_clkgen (
	output logic lb_clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		lb_clk = 1'b0;
		forever #20 lb_clk = ~lb_clk; // 40 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge lb_clk);
		@(negedge lb_clk) arst_n = 1'b1; // release away from the active edge
	end

endmodule

// ==== tb.f ====
design/digitizer_pkg.sv
design/digitizer_regs.sv
design/idelay_autoset.sv
design/idelay_arbiter.sv
design/idelay_loader.sv
design/digitizer_config.sv
sim/tb_clkgen.sv
sim/digitizer_checker.sv
sim/digitizer_config_sva.sv
sim/digitizer_config_tb.sv
